//--- source/kuz_ctrl_pkg.sv
package kuz_ctrl_pkg;

  // Datapath widths.
  localparam int BLOCK_W = 128;  // Block and round key.
  localparam int KEY_W   = 256;  // Master key.

  // Schedule and round counts.
  localparam int NUM_RKEYS     = 10;
  localparam int NUM_ROUNDS    = 9;   // Full rounds, last key is a plain XOR.
  localparam int FEISTEL_STEPS = 32;  // Eight per round-key pair.

  // Counter widths.
  localparam int RK_IDX_W = 4;   // Holds 0 to NUM_RKEYS-1.
  localparam int STEP_W   = 5;   // Holds 0 to FEISTEL_STEPS-1.

endpackage

//--- source/kuz_cipher_pkg.sv
package kuz_cipher_pkg;

  // Nonlinear bijection pi, indexed by input byte.
  localparam logic [7:0] SBOX_FWD [256] = '{
    252, 238, 221,  17, 207, 110,  49,  22, 251, 196, 250, 218,  35, 197,   4,  77,
    233, 119, 240, 219, 147,  46, 153, 186,  23,  54, 241, 187,  20, 205,  95, 193,
    249,  24, 101,  90, 226,  92, 239,  33, 129,  28,  60,  66, 139,   1, 142,  79,
      5, 132,   2, 174, 227, 106, 143, 160,   6,  11, 237, 152, 127, 212, 211,  31,
    235,  52,  44,  81, 234, 200,  72, 171, 242,  42, 104, 162, 253,  58, 206, 204,
    181, 112,  14,  86,   8,  12, 118,  18, 191, 114,  19,  71, 156, 183,  93, 135,
     21, 161, 150,  41,  16, 123, 154, 199, 243, 145, 120, 111, 157, 158, 178, 177,
     50, 117,  25,  61, 255,  53, 138, 126, 109,  84, 198, 128, 195, 189,  13,  87,
    223, 245,  36, 169,  62, 168,  67, 201, 215, 121, 214, 246, 124,  34, 185,   3,
    224,  15, 236, 222, 122, 148, 176, 188, 220, 232,  40,  80,  78,  51,  10,  74,
    167, 151,  96, 115,  30,   0,  98,  68,  26, 184,  56, 130, 100, 159,  38,  65,
    173,  69,  70, 146,  39,  94,  85,  47, 140, 163, 165, 125, 105, 213, 149,  59,
      7,  88, 179,  64, 134, 172,  29, 247,  48,  55, 107, 228, 136, 217, 231, 137,
    225,  27, 131,  73,  76,  63, 248, 254, 141,  83, 170, 144, 202, 216, 133,  97,
     32, 113, 103, 164,  45,  43,   9,  91, 203, 155,  37, 208, 190, 229, 108,  82,
     89, 166, 116, 210, 230, 244, 180, 192, 209, 102, 175, 194,  57,  75,  99, 182
  };

  localparam logic [7:0] SBOX_INV [256] = '{
    165,  45,  50, 143,  14,  48,  56, 192,  84, 230, 158,  57,  85, 126,  82, 145,
    100,   3,  87,  90,  28,  96,   7,  24,  33, 114, 168, 209,  41, 198, 164,  63,
    224,  39, 141,  12, 130, 234, 174, 180, 154,  99,  73, 229,  66, 228,  21, 183,
    200,   6, 112, 157,  65, 117,  25, 201, 170, 252,  77, 191,  42, 115, 132, 213,
    195, 175,  43, 134, 167, 177, 178,  91,  70, 211, 159, 253, 212,  15, 156,  47,
    155,  67, 239, 217, 121, 182,  83, 127, 193, 240,  35, 231,  37,  94, 181,  30,
    162, 223, 166, 254, 172,  34, 249, 226,  74, 188,  53, 202, 238, 120,   5, 107,
     81, 225,  89, 163, 242, 113,  86,  17, 106, 137, 148, 101, 140, 187, 119,  60,
    123,  40, 171, 210,  49, 222, 196,  95, 204, 207, 118,  44, 184, 216,  46,  54,
    219, 105, 179,  20, 149, 190,  98, 161,  59,  22, 102, 233,  92, 108, 109, 173,
     55,  97,  75, 185, 227, 186, 241, 160, 133, 131, 218,  71, 197, 176,  51, 250,
    150, 111, 110, 194, 246,  80, 255,  93, 169, 142,  23,  27, 151, 125, 236,  88,
    247,  31, 251, 124,   9,  13, 122, 103,  69, 135, 220, 232,  79,  29,  78,   4,
    235, 248, 243,  62,  61, 189, 138, 136, 221, 205,  11,  19, 152,   2, 147, 128,
    144, 208,  36,  52, 203, 237, 244, 206, 153,  16,  68,  64, 146,  58,   1,  38,
     18,  26,  72, 104, 245, 129, 139, 199, 214,  32,  10,   8,   0,  76, 215, 116
  };

  // Entry 0 weights the most significant byte.
  localparam logic [7:0] LIN_COEF [16] = '{
    148,  32, 133,  16, 194, 192,   1, 251,
      1, 192, 194,  16, 133,  32, 148,   1
  };

  localparam logic [7:0] GF_POLY = 8'hC3; // x^8 + x^7 + x^6 + x + 1, top bit implied.

  // Shift-and-add product in GF(2^8).
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] sh;
    acc = 8'h00;
    sh  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? GF_POLY : 8'h00);
    end
    return acc;
  endfunction

endpackage

//--- source/kuz_sbox.sv
`timescale 1ns/1ps

module kuz_sbox (
  input  logic [kuz_ctrl_pkg::BLOCK_W-1:0] data_i,
  input  logic                             inverse_i,
  output logic [kuz_ctrl_pkg::BLOCK_W-1:0] data_o
);
  import kuz_ctrl_pkg::*;
  import kuz_cipher_pkg::*;

  // Each byte goes through its own table lookup.
  always_comb begin
    for (int i = 0; i < BLOCK_W / 8; i++) begin
      if (inverse_i) begin
        data_o[i*8 +: 8] = SBOX_INV[data_i[i*8 +: 8]];
      end else begin
        data_o[i*8 +: 8] = SBOX_FWD[data_i[i*8 +: 8]];
      end
    end
  end

endmodule

//--- source/kuz_lin.sv
`timescale 1ns/1ps

module kuz_lin (
  input  logic [kuz_ctrl_pkg::BLOCK_W-1:0] data_i,
  input  logic                             inverse_i,
  output logic [kuz_ctrl_pkg::BLOCK_W-1:0] data_o
);
  import kuz_ctrl_pkg::*;
  import kuz_cipher_pkg::*;

  logic [BLOCK_W-1:0] st;
  logic [BLOCK_W-1:0] rot;

  // Linear functional over the 16 bytes, MSB byte first.
  function automatic logic [7:0] lin_byte(input logic [BLOCK_W-1:0] v);
    logic [7:0] acc;
    acc = 8'h00;
    for (int i = 0; i < 16; i++) begin
      acc = acc ^ gf_mul(LIN_COEF[i], v[BLOCK_W-1-8*i -: 8]);
    end
    return acc;
  endfunction

  // L is R applied 16 times.
  always_comb begin
    st  = data_i;
    rot = '0;
    for (int r = 0; r < 16; r++) begin
      if (inverse_i) begin
        rot = {st[BLOCK_W-9:0], st[BLOCK_W-1 -: 8]};  // Bring the new byte back into place.
        st  = {st[BLOCK_W-9:0], lin_byte(rot)};
      end else begin
        st = {lin_byte(st), st[BLOCK_W-1:8]};
      end
    end
    data_o = st;
  end

endmodule

//--- source/kuz_round.sv
`timescale 1ns/1ps

module kuz_round (
  input  logic [kuz_ctrl_pkg::BLOCK_W-1:0] state_i,
  input  logic [kuz_ctrl_pkg::BLOCK_W-1:0] rkey_i,
  input  logic                             inverse_i,
  output logic [kuz_ctrl_pkg::BLOCK_W-1:0] state_o
);
  import kuz_ctrl_pkg::*;

  logic [BLOCK_W-1:0] fwd_sub;
  logic [BLOCK_W-1:0] fwd_out;
  logic [BLOCK_W-1:0] inv_lin;
  logic [BLOCK_W-1:0] inv_sub;

  // XSL path.
  kuz_sbox u_sbox_fwd (
    .data_i    (state_i ^ rkey_i),
    .inverse_i (1'b0),
    .data_o    (fwd_sub)
  );

  kuz_lin u_lin_fwd (
    .data_i    (fwd_sub),
    .inverse_i (1'b0),
    .data_o    (fwd_out)
  );

  // LSX path, kept separate so the two orders never form a loop.
  kuz_lin u_lin_inv (
    .data_i    (state_i),
    .inverse_i (1'b1),
    .data_o    (inv_lin)
  );

  kuz_sbox u_sbox_inv (
    .data_i    (inv_lin),
    .inverse_i (1'b1),
    .data_o    (inv_sub)
  );

  assign state_o = inverse_i ? (inv_sub ^ rkey_i) : fwd_out;

endmodule

//--- source/kuz_key_expand.sv
`timescale 1ns/1ps

module kuz_key_expand (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              load_i,
  input  logic [kuz_ctrl_pkg::KEY_W-1:0]    key_i,
  input  logic [kuz_ctrl_pkg::RK_IDX_W-1:0] rk_idx_i,
  output logic [kuz_ctrl_pkg::BLOCK_W-1:0]  rkey_o,
  output logic                              ready_o
);
  import kuz_ctrl_pkg::*;

  logic [BLOCK_W-1:0]  left_q;
  logic [BLOCK_W-1:0]  right_q;
  logic [STEP_W-1:0]   step_q;
  logic                run_q;
  logic                ready_q;
  logic [BLOCK_W-1:0]  rk_q [NUM_RKEYS];

  logic [BLOCK_W-1:0]  step_vec;
  logic [BLOCK_W-1:0]  step_const;
  logic [BLOCK_W-1:0]  f_out;
  logic [BLOCK_W-1:0]  left_nxt;
  logic [RK_IDX_W-1:0] pair_idx;
  logic                pair_done;
  logic                last_step;

  // Step constant C(i) = L(i), numbered from one.
  assign step_vec = BLOCK_W'(step_q) + BLOCK_W'(1);

  kuz_lin u_const (
    .data_i    (step_vec),
    .inverse_i (1'b0),
    .data_o    (step_const)
  );

  // Feistel function, LSX of the left half under the step constant.
  kuz_round u_f (
    .state_i   (left_q),
    .rkey_i    (step_const),
    .inverse_i (1'b0),
    .state_o   (f_out)
  );

  assign left_nxt  = f_out ^ right_q;
  assign pair_done = (step_q[2:0] == 3'd7);
  assign last_step = (step_q == STEP_W'(FEISTEL_STEPS - 1));
  assign pair_idx  = RK_IDX_W'({step_q[STEP_W-1:3], 1'b0}) + RK_IDX_W'(2);  // K3/K4 first.

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      run_q   <= 1'b0;
      ready_q <= 1'b0;
      step_q  <= '0;
    end else if (load_i) begin
      run_q   <= 1'b1;
      ready_q <= 1'b0;
      step_q  <= '0;
    end else if (run_q) begin
      step_q <= step_q + 1'b1;
      if (last_step) begin
        run_q   <= 1'b0;
        ready_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      left_q  <= key_i[KEY_W-1 -: BLOCK_W];
      right_q <= key_i[BLOCK_W-1:0];
      rk_q[0] <= key_i[KEY_W-1 -: BLOCK_W];  // K1.
      rk_q[1] <= key_i[BLOCK_W-1:0];         // K2.
    end else if (run_q) begin
      left_q  <= left_nxt;
      right_q <= left_q;
      if (pair_done) begin
        rk_q[pair_idx]        <= left_nxt;
        rk_q[pair_idx + 1'b1] <= left_q;
      end
    end
  end

  assign rkey_o  = rk_q[rk_idx_i];
  assign ready_o = ready_q;

endmodule

//--- source/kuz_core.sv
`timescale 1ns/1ps

module kuz_core (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             key_load_i,
  input  logic [kuz_ctrl_pkg::KEY_W-1:0]   key_i,
  input  logic                             start_i,
  input  logic [kuz_ctrl_pkg::BLOCK_W-1:0] block_i,
  input  logic                             decrypt_i,
  output logic [kuz_ctrl_pkg::BLOCK_W-1:0] data_o,
  output logic                             done_o,
  output logic                             busy_o,
  output logic                             key_ready_o
);
  import kuz_ctrl_pkg::*;

  logic                key_load;
  logic                start;
  logic                key_ready;
  logic                last_round;
  logic                busy_q;
  logic                done_q;
  logic                dec_q;
  logic [RK_IDX_W-1:0] round_q;
  logic [RK_IDX_W-1:0] rk_idx;
  logic [BLOCK_W-1:0]  rkey;
  logic [BLOCK_W-1:0]  k_last_q;
  logic [BLOCK_W-1:0]  state_q;
  logic [BLOCK_W-1:0]  round_out;
  logic [BLOCK_W-1:0]  data_q;

  // A key load in the same cycle wins over a start.
  assign key_load   = key_load_i & ~busy_q;
  assign start      = start_i & ~busy_q & key_ready & ~key_load_i;
  assign last_round = busy_q & (round_q == RK_IDX_W'(NUM_ROUNDS - 1));

  // Idle index points at K10 so it can be captured at start.
  always_comb begin
    if (!busy_q) begin
      rk_idx = RK_IDX_W'(NUM_RKEYS - 1);
    end else if (dec_q) begin
      rk_idx = RK_IDX_W'(NUM_ROUNDS - 1) - round_q;  // K9 down to K1.
    end else begin
      rk_idx = round_q;                              // K1 up to K9.
    end
  end

  kuz_key_expand u_key_expand (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .load_i   (key_load),
    .key_i    (key_i),
    .rk_idx_i (rk_idx),
    .rkey_o   (rkey),
    .ready_o  (key_ready)
  );

  kuz_round u_round (
    .state_i   (state_q),
    .rkey_i    (rkey),
    .inverse_i (dec_q),
    .state_o   (round_out)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      dec_q   <= 1'b0;
      round_q <= '0;
      data_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        busy_q  <= 1'b1;
        dec_q   <= decrypt_i;
        round_q <= '0;
      end else if (busy_q) begin
        round_q <= round_q + 1'b1;
        if (last_round) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
          data_q <= dec_q ? round_out : (round_out ^ k_last_q);  // Final whitening.
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      k_last_q <= rkey;
      state_q  <= decrypt_i ? (block_i ^ rkey) : block_i;
    end else if (busy_q) begin
      state_q <= round_out;
    end
  end

  assign data_o      = data_q;
  assign done_o      = done_q;
  assign busy_o      = busy_q;
  assign key_ready_o = key_ready;

endmodule

//--- tests/kuz_core_asserts.sv
`timescale 1ns/1ps

module kuz_core_asserts (
  input logic clk_i,
  input logic rst_n_i,
  input logic done_i,
  input logic busy_i,
  input logic key_ready_i
);

  int fail_count = 0;  // Failed assertions so far.

  // A result strobe lasts one cycle.
  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done_o stayed high for two cycles");
    end

  a_done_after_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> $past(busy_i))
    else begin
      fail_count++;
      $error("done_o pulsed without busy_o in the cycle before");
    end

  a_reset_clear: assert property (@(posedge clk_i)
    !rst_n_i |=> (!key_ready_i && !busy_i && !done_i))
    else begin
      fail_count++;
      $error("status outputs not cleared by reset");
    end

endmodule

bind kuz_core kuz_core_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .done_i      (done_o),
  .busy_i      (busy_o),
  .key_ready_i (key_ready_o)
);

//--- tests/kuz_tb.sv
`timescale 1ns/1ps

module kuz_tb;
  import kuz_ctrl_pkg::*;

  localparam int CLK_HALF      = 20;
  localparam int DRIVE_DLY     = 2;
  localparam int RESET_CYCLES  = 4;
  localparam int KEY_TIMEOUT   = 100;
  localparam int BLOCK_TIMEOUT = 50;
  localparam int NO_DONE_WIN   = 40;
  localparam int MAX_CMDS      = 1000;

  logic               clk_i;
  logic               rst_n_i;
  logic               key_load_i;
  logic [KEY_W-1:0]   key_i;
  logic               start_i;
  logic [BLOCK_W-1:0] block_i;
  logic               decrypt_i;
  logic [BLOCK_W-1:0] data_o;
  logic               done_o;
  logic               busy_o;
  logic               key_ready_o;

  logic [BLOCK_W-1:0] last_result;  // Value data_o must hold between blocks.
  int                 err_count;

  kuz_core uut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .key_load_i  (key_load_i),
    .key_i       (key_i),
    .start_i     (start_i),
    .block_i     (block_i),
    .decrypt_i   (decrypt_i),
    .data_o      (data_o),
    .done_o      (done_o),
    .busy_o      (busy_o),
    .key_ready_o (key_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic stop_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [BLOCK_W-1:0] got, input logic [BLOCK_W-1:0] exp,
                             input string what);
    if (got !== exp) begin
      err_count++;
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
    end
  endtask

  always @(posedge clk_i) begin
    if (uut.u_asserts.fail_count != 0) begin
      stop_run("a bound assertion on kuz_core failed");
    end
  end

  // Step to just past the next rising edge.
  task automatic next_cycle();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic load_key(input logic [KEY_W-1:0] key);
    int cycles;
    key_i      = key;
    key_load_i = 1'b1;
    next_cycle();
    key_load_i = 1'b0;
    check_value(BLOCK_W'(key_ready_o), '0, "key_ready_o after accepted load");
    cycles = 0;
    while (!key_ready_o && cycles < KEY_TIMEOUT) begin
      next_cycle();
      cycles++;
    end
    if (!key_ready_o) begin
      stop_run("key_ready_o never rose after a key load");
    end
    check_value(BLOCK_W'(cycles), BLOCK_W'(FEISTEL_STEPS), "load to key_ready_o in cycles");
  endtask

  task automatic run_block(input logic [BLOCK_W-1:0] blk, input logic dec, input bit stray,
                           output logic [BLOCK_W-1:0] res);
    int cycles;
    int i;
    block_i   = blk;
    decrypt_i = dec;
    start_i   = 1'b1;
    next_cycle();
    start_i = 1'b0;
    check_value(BLOCK_W'(busy_o), BLOCK_W'(1), "busy_o after accepted start");
    cycles = 0;
    while (!done_o && cycles < BLOCK_TIMEOUT) begin
      if (stray && cycles == 0) begin
        block_i   = ~blk;  // Different result if it were taken.
        decrypt_i = ~dec;
        start_i   = 1'b1;
      end
      next_cycle();
      start_i = 1'b0;
      cycles++;
      if (!done_o) begin
        check_value(data_o, last_result, "data_o changed before done_o");
      end
    end
    if (!done_o) begin
      stop_run("done_o did not pulse after an accepted start");
    end
    check_value(BLOCK_W'(cycles), BLOCK_W'(NUM_ROUNDS), "start to done_o in cycles");
    check_value(BLOCK_W'(busy_o), '0, "busy_o in the done_o cycle");
    res         = data_o;
    last_result = data_o;
    for (i = 0; i < (stray ? NO_DONE_WIN : 2); i++) begin
      next_cycle();
      check_value(BLOCK_W'(done_o), '0, "second done_o after one block");
      check_value(data_o, res, "data_o not held after done_o");
    end
  endtask

  task automatic start_without_key();
    int i;
    if (key_ready_o) begin
      stop_run("key_ready_o is already high, a keyless start cannot be tried");
    end
    block_i   = '1;
    decrypt_i = 1'b0;
    start_i   = 1'b1;
    next_cycle();
    start_i = 1'b0;
    for (i = 0; i < NO_DONE_WIN; i++) begin
      check_value(BLOCK_W'(done_o), '0, "done_o after a start without a key");
      check_value(BLOCK_W'(busy_o), '0, "busy_o after a start without a key");
      next_cycle();
    end
  endtask

  task automatic round_trips(input int count);
    logic [BLOCK_W-1:0] plain;
    logic [BLOCK_W-1:0] cipher;
    logic [BLOCK_W-1:0] back;
    int i;
    for (i = 0; i < count; i++) begin
      plain = {$urandom(), $urandom(), $urandom(), $urandom()};
      run_block(plain, 1'b0, 1'b0, cipher);
      run_block(cipher, 1'b1, 1'b0, back);
      check_value(back, plain, "decrypted random block");
    end
  endtask

  initial begin
    int               fd;
    int               code;
    int               n_cmds;
    int               count;
    int               seed;
    logic [8*16-1:0]  cmd;
    logic [8*256-1:0] rest;
    logic [KEY_W-1:0] key_val;
    logic [BLOCK_W-1:0] in_val;
    logic [BLOCK_W-1:0] exp_val;
    logic [BLOCK_W-1:0] res;

    seed        = $urandom(91);
    err_count   = 0;
    last_result = '0;
    rst_n_i     = 1'b0;
    key_load_i  = 1'b0;
    key_i       = '0;
    start_i     = 1'b0;
    block_i     = '0;
    decrypt_i   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    check_value(BLOCK_W'(key_ready_o), '0, "key_ready_o after reset");
    check_value(BLOCK_W'(busy_o), '0, "busy_o after reset");
    check_value(BLOCK_W'(done_o), '0, "done_o after reset");
    check_value(data_o, '0, "data_o after reset");

    fd = $fopen("tests/kuz_input.txt", "r");
    if (fd == 0) begin
      stop_run("could not open tests/kuz_input.txt");
    end
    n_cmds = 0;
    while (n_cmds < MAX_CMDS) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        break;
      end
      n_cmds++;
      case (cmd)
        "#": code = $fgets(rest, fd);  // Rest of a comment line.
        "N": start_without_key();
        "K": begin
          code = $fscanf(fd, "%h", key_val);
          if (code != 1) begin
            stop_run("key line in the data file is malformed");
          end
          load_key(key_val);
        end
        "E", "D", "B": begin
          code = $fscanf(fd, "%h %h", in_val, exp_val);
          if (code != 2) begin
            stop_run("block line in the data file is malformed");
          end
          run_block(in_val, cmd == "D", cmd == "B", res);
          check_value(res, exp_val, "block result");
        end
        "R": begin
          code = $fscanf(fd, "%d", count);
          if (code != 1) begin
            stop_run("round trip line in the data file is malformed");
          end
          round_trips(count);
        end
        default: stop_run("unknown command in the data file");
      endcase
    end
    $fclose(fd);
    if (n_cmds == 0) begin
      stop_run("the data file holds no commands");
    end

    if (err_count == 0 && uut.u_asserts.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- tests/kuz_input.txt
# Columns: command letter, then operands in hex unless noted.
# N start with no key | K key | E or D input expected | B encrypt with a start while busy | R count
N
K 8899aabbccddeeff0011223344556677fedcba98765432100123456789abcdef
E 1122334455667700ffeeddccbbaa9988 7f679d90bebc24305a468d42b9d4edcd
D 7f679d90bebc24305a468d42b9d4edcd 1122334455667700ffeeddccbbaa9988
E 1122334455667700ffeeddccbbaa9988 7f679d90bebc24305a468d42b9d4edcd
B 1122334455667700ffeeddccbbaa9988 7f679d90bebc24305a468d42b9d4edcd
D 7f679d90bebc24305a468d42b9d4edcd 1122334455667700ffeeddccbbaa9988
R 6
# Second key, round trips only.
K 000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f
R 4
# Back to the test key, known answers again.
K 8899aabbccddeeff0011223344556677fedcba98765432100123456789abcdef
D 7f679d90bebc24305a468d42b9d4edcd 1122334455667700ffeeddccbbaa9988
E 1122334455667700ffeeddccbbaa9988 7f679d90bebc24305a468d42b9d4edcd
B 1122334455667700ffeeddccbbaa9988 7f679d90bebc24305a468d42b9d4edcd
R 4

//--- filelist.f
source/kuz_ctrl_pkg.sv
source/kuz_cipher_pkg.sv
source/kuz_sbox.sv
source/kuz_lin.sv
source/kuz_round.sv
source/kuz_key_expand.sv
source/kuz_core.sv
tests/kuz_core_asserts.sv
tests/kuz_tb.sv
